/* verilog/hawk_tbl_pkg.sv */
/*
 * table layout shared by the page-table write manager
 * entry ids start at 1 and id 0 is the null pointer
 * sizes and base addresses are fixed here and nowhere else
 */
`default_nettype none

package hawk_tbl_pkg;

	typedef logic [23:0] entry_id_t; // att or list index
	typedef logic [47:0] way_t;      // 4KB physical page number

	localparam entry_id_t NULL_ID = 24'd0;        // no entry
	localparam entry_id_t ATT_ENTRY_CNT = 24'd16;  // 2 att lines
	localparam entry_id_t LIST_ENTRY_CNT = 24'd8;  // 2 list lines

	// byte addresses of both tables, line aligned
	localparam logic [63:0] ATT_BASE = 64'h0000_0000_8000_0000;
	localparam logic [63:0] LIST_BASE = 64'h0000_0000_8000_1000;

	// first page handed out as a way by list init
	localparam way_t PPA_BASE_PAGE = 48'h0000_0009_0000;

	typedef enum logic [1:0] {
		DALLOC = 2'd0, // not allocated
		UNCOMP = 2'd1, // page held uncompressed
		COMP   = 2'd2  // page held compressed
	} att_sts_e;

	// 64 bit att entry, eight per line
	typedef struct packed {
		logic [5:0] rsvd;    // always zero
		logic [7:0] zpd_cnt; // zero page count
		way_t       way;
		att_sts_e   sts;
	} att_entry_t;

	// 128 bit list entry, four per line
	typedef struct packed {
		logic [7:0] rsvd;   // bits 127:120
		way_t       way;    // bits 119:72
		entry_id_t  att_id; // bits 71:48
		entry_id_t  prev;   // bits 47:24
		entry_id_t  next;   // bits 23:0
	} list_entry_t;

	// table write operations
	typedef enum logic [2:0] {
		ATT_INIT    = 3'd0, // att entry as deallocated
		LIST_INIT   = 3'd1, // full free list entry
		ATT_ALLOC   = 3'd2, // att entry to uncompressed
		FREE_POP    = 3'd3, // prev of new free head
		UNCOMP_PUSH = 3'd4, // next, prev and att id of pushed entry
		TAIL_LINK   = 3'd5  // next of old uncompressed tail
	} tbl_op_e;

endpackage

`default_nettype wire

/* verilog/hawk_axi_pkg.sv */
/*
 * write bus view of one cache line
 * single beat bursts only, one line per address
 */
`default_nettype none

package hawk_axi_pkg;

	localparam int LINE_BYTES = 64;
	localparam int ADDR_W = 64;

	typedef logic [LINE_BYTES*8-1:0] line_data_t;
	typedef logic [LINE_BYTES-1:0] line_strb_t;

	// one packed line write
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		line_data_t        data;
		line_strb_t        strb; // byte enables with unwritten data bytes zero
	} line_wr_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

endpackage

`default_nettype wire

/* verilog/hawk_tbl_op_if.sv */
/*
 * one table op from sequencer to line packer
 * fields stay stable while valid is high and ready is low
 */
`timescale 1ns/100ps
`default_nettype none

interface hawk_tbl_op_if
	import hawk_tbl_pkg::*;
();
	logic      valid;
	logic      ready;
	tbl_op_e   op;
	entry_id_t id;     // entry being written
	way_t      way;
	entry_id_t ptr_a;  // prev, or the lone pointer written
	entry_id_t ptr_b;  // next
	entry_id_t att_id;
	logic [7:0] zpd;   // zero page count for att ops

	modport src (output valid, op, id, way, ptr_a, ptr_b, att_id, zpd, input ready);
	modport sink (input valid, op, id, way, ptr_a, ptr_b, att_id, zpd, output ready);

endinterface

`default_nettype wire

/* verilog/hawk_line_wr_if.sv */
/*
 * one packed line write from packer to bus issuer
 * pkt stays stable while valid is high and ready is low
 */
`timescale 1ns/100ps
`default_nettype none

interface hawk_line_wr_if
	import hawk_axi_pkg::*;
();
	logic     valid;
	logic     ready;
	line_wr_t pkt; // address, data and byte strobes

	modport src (output valid, pkt, input ready);
	modport sink (input valid, pkt, output ready);

endinterface

`default_nettype wire

/* verilog/hawk_tbl_sequencer.sv */
/*
 * mode FSM with entry counter and free/uncompressed head and tail registers
 * each init runs once, att before list, and updates are taken only in IDLE
 * update caller supplies the popped free entry and its next pointer
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_tbl_sequencer
	import hawk_tbl_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  logic       upd_valid,
	input  entry_id_t  upd_att_id,
	input  entry_id_t  upd_tol_id,
	input  entry_id_t  upd_next,
	input  way_t       upd_way,
	input  logic [7:0] upd_zpd,
	input  logic       idle,     // issuer has nothing held or outstanding
	hawk_tbl_op_if.src op,
	output logic       ready,
	output logic       att_init_done,
	output logic       list_init_done,
	output logic       upd_done,
	output entry_id_t  free_head,
	output entry_id_t  free_tail,
	output entry_id_t  uncomp_head,
	output entry_id_t  uncomp_tail
);

	typedef enum logic [2:0] {IDLE, ATT_INIT, LIST_INIT, ALLOC, POP, PUSH, LINK, DRAIN} state_e;

	state_e state, n_state;
	entry_id_t cnt, n_cnt;
	logic n_vld;
	logic n_att_done, n_list_done, n_upd_done;
	entry_id_t n_free_head, n_free_tail, n_uncomp_head, n_uncomp_tail;
	tbl_op_e n_op;
	entry_id_t n_id, n_ptr_a, n_ptr_b, n_att_id;
	way_t n_way;
	logic [7:0] n_zpd;
	entry_id_t u_att_id, u_tol_id, u_next; // latched update request
	logic att_go, list_go, upd_acc, xfer;

	// next pointer of a freshly built free list
	function automatic entry_id_t list_next(input entry_id_t id);
		list_next = (id == LIST_ENTRY_CNT) ? NULL_ID : id + 24'd1;
	endfunction

	assign ready = (state == IDLE);
	assign att_go = init_att && !att_init_done;
	assign list_go = init_list && !list_init_done;
	assign upd_acc = ready && upd_valid && !att_go && !list_go;
	assign xfer = op.valid && op.ready;

	always_comb begin
		n_state = state;
		n_cnt = cnt;
		n_vld = op.valid;
		n_att_done = att_init_done;
		n_list_done = list_init_done;
		n_upd_done = 1'b0; // strobe
		n_free_head = free_head;
		n_free_tail = free_tail;
		n_uncomp_head = uncomp_head;
		n_uncomp_tail = uncomp_tail;
		n_op = op.op; // payload holds unless a new op loads
		n_id = op.id;
		n_way = op.way;
		n_ptr_a = op.ptr_a;
		n_ptr_b = op.ptr_b;
		n_att_id = op.att_id;
		n_zpd = op.zpd;
		case (state)
			IDLE: begin
				if (att_go) begin
					n_state = ATT_INIT;
					n_cnt = 24'd1;
					n_vld = 1'b1;
					n_op = hawk_tbl_pkg::ATT_INIT;
					n_id = 24'd1;
					n_way = '0; // deallocated entries carry no way
					n_zpd = 8'd0;
					n_ptr_a = NULL_ID;
					n_ptr_b = NULL_ID;
					n_att_id = NULL_ID;
				end else if (list_go) begin
					n_state = LIST_INIT;
					n_cnt = 24'd1;
					n_vld = 1'b1;
					n_op = hawk_tbl_pkg::LIST_INIT;
					n_id = 24'd1;
					n_way = PPA_BASE_PAGE;
					n_zpd = 8'd0;
					n_ptr_a = NULL_ID;  // first entry has no prev
					n_ptr_b = list_next(24'd1);
					n_att_id = NULL_ID;
				end else if (upd_acc) begin
					n_state = ALLOC;
					n_vld = 1'b1;
					n_op = ATT_ALLOC;
					n_id = upd_att_id;
					n_way = upd_way;
					n_zpd = upd_zpd;
				end
			end
			ATT_INIT: begin
				if (xfer) begin
					if (cnt == ATT_ENTRY_CNT) begin
						n_vld = 1'b0;
						n_state = DRAIN;
					end else begin
						n_cnt = cnt + 24'd1;
						n_id = cnt + 24'd1;
					end
				end
			end
			LIST_INIT: begin
				if (xfer) begin
					if (cnt == LIST_ENTRY_CNT) begin
						n_vld = 1'b0;
						n_free_head = 24'd1; // whole table is one free list
						n_free_tail = LIST_ENTRY_CNT;
						n_state = DRAIN;
					end else begin
						n_cnt = cnt + 24'd1;
						n_id = cnt + 24'd1;
						n_ptr_a = cnt;
						n_ptr_b = list_next(cnt + 24'd1);
						n_way = op.way + 48'd1; // next page
					end
				end
			end
			ALLOC: begin
				if (xfer) begin
					if (free_head != free_tail) begin
						n_state = POP;
						n_op = FREE_POP;
						n_id = u_next;
						n_ptr_a = NULL_ID; // new head loses its prev
						n_ptr_b = NULL_ID;
						n_att_id = NULL_ID;
					end else begin
						n_free_head = NULL_ID; // last free entry taken
						n_free_tail = NULL_ID;
						n_state = PUSH;
						n_op = UNCOMP_PUSH;
						n_id = u_tol_id;
						n_ptr_a = uncomp_tail;
						n_ptr_b = NULL_ID;
						n_att_id = u_att_id;
					end
				end
			end
			POP: begin
				if (xfer) begin
					n_free_head = u_next;
					n_state = PUSH;
					n_op = UNCOMP_PUSH;
					n_id = u_tol_id;
					n_ptr_a = uncomp_tail; // prev is old tail
					n_ptr_b = NULL_ID;
					n_att_id = u_att_id;
				end
			end
			PUSH: begin
				if (xfer) begin
					if (uncomp_tail != NULL_ID) begin
						n_state = LINK;
						n_op = TAIL_LINK;
						n_id = uncomp_tail;
						n_ptr_a = u_tol_id; // old tail now points at us
						n_ptr_b = NULL_ID;
					end else begin
						n_uncomp_head = u_tol_id; // first push
						n_uncomp_tail = u_tol_id;
						n_vld = 1'b0;
						n_state = DRAIN;
					end
				end
			end
			LINK: begin
				if (xfer) begin
					n_uncomp_tail = u_tol_id;
					n_vld = 1'b0;
					n_state = DRAIN;
				end
			end
			DRAIN: begin
				if (idle) begin // last op left the packer and got its response
					n_state = IDLE;
					case (op.op)
						hawk_tbl_pkg::ATT_INIT:  n_att_done = 1'b1;
						hawk_tbl_pkg::LIST_INIT: n_list_done = 1'b1;
						default:                 n_upd_done = 1'b1;
					endcase
				end
			end
			default: n_state = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state <= IDLE;
			cnt <= NULL_ID;
			op.valid <= 1'b0;
			att_init_done <= 1'b0;
			list_init_done <= 1'b0;
			upd_done <= 1'b0;
			free_head <= NULL_ID;
			free_tail <= NULL_ID;
			uncomp_head <= NULL_ID;
			uncomp_tail <= NULL_ID;
		end else begin
			state <= n_state;
			cnt <= n_cnt;
			op.valid <= n_vld;
			att_init_done <= n_att_done;
			list_init_done <= n_list_done;
			upd_done <= n_upd_done;
			free_head <= n_free_head;
			free_tail <= n_free_tail;
			uncomp_head <= n_uncomp_head;
			uncomp_tail <= n_uncomp_tail;
		end
	end

	// op payload and update latch
	always_ff @(posedge clk_i) begin
		op.op <= n_op;
		op.id <= n_id;
		op.way <= n_way;
		op.ptr_a <= n_ptr_a;
		op.ptr_b <= n_ptr_b;
		op.att_id <= n_att_id;
		op.zpd <= n_zpd;
		if (upd_acc) begin
			u_att_id <= upd_att_id;
			u_tol_id <= upd_tol_id;
			u_next <= upd_next;
		end
	end

	// an update is never offered while an init is pending or running
	upd_vs_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
		upd_valid |-> !(att_go || list_go || state inside {ATT_INIT, LIST_INIT}));

endmodule

`default_nettype wire

/* verilog/hawk_line_packer.sv */
/*
 * maps a table op onto one line write with slot placed data and strobes
 * bytes outside the strobe are zero
 * one output register, refilled in the cycle it drains
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_line_packer
	import hawk_tbl_pkg::*;
	import hawk_axi_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	hawk_tbl_op_if.sink op,
	hawk_line_wr_if.src line
);

	entry_id_t   idx;      // zero based entry index
	logic        att_op;
	att_entry_t  att_ent;
	list_entry_t lst_ent;
	logic [15:0] lst_strb; // bytes of the 16 byte list entry
	line_wr_t    nxt;
	line_wr_t    pkt_q;
	logic        vld_q;

	assign idx = op.id - 24'd1;
	assign att_op = (op.op == ATT_INIT) || (op.op == ATT_ALLOC);

	always_comb begin
		att_ent = '0;
		att_ent.zpd_cnt = op.zpd;
		att_ent.way = op.way;
		att_ent.sts = (op.op == ATT_ALLOC) ? UNCOMP : DALLOC;
		lst_ent = '0;
		lst_strb = 16'h0000;
		case (op.op)
			LIST_INIT: begin
				lst_ent.way = op.way;
				lst_ent.att_id = op.att_id;
				lst_ent.prev = op.ptr_a;
				lst_ent.next = op.ptr_b;
				lst_strb = 16'hffff; // whole entry
			end
			FREE_POP: begin
				lst_ent.prev = op.ptr_a;
				lst_strb = 16'h0038; // prev field only
			end
			UNCOMP_PUSH: begin
				lst_ent.att_id = op.att_id;
				lst_ent.prev = op.ptr_a;
				lst_ent.next = op.ptr_b;
				lst_strb = 16'h01ff; // next, prev, att id
			end
			TAIL_LINK: begin
				lst_ent.next = op.ptr_a;
				lst_strb = 16'h0007; // next field only
			end
			default: ;
		endcase
		if (att_op) begin
			// eight entries per line
			nxt.addr = ATT_BASE + {37'd0, idx[23:3], 6'd0};
			nxt.data = line_data_t'(att_ent) << {idx[2:0], 6'd0};
			nxt.strb = line_strb_t'(8'hff) << {idx[2:0], 3'd0};
		end else begin
			// four entries per line
			nxt.addr = LIST_BASE + {36'd0, idx[23:2], 6'd0};
			nxt.data = line_data_t'(lst_ent) << {idx[1:0], 7'd0};
			nxt.strb = line_strb_t'(lst_strb) << {idx[1:0], 4'd0};
		end
	end

	assign op.ready = !vld_q || line.ready; // empty or draining now

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= 1'b0;
		end else if (op.ready) begin
			vld_q <= op.valid;
		end
	end

	always_ff @(posedge clk_i) begin
		if (op.valid && op.ready) begin
			pkt_q <= nxt;
		end
	end

	assign line.valid = vld_q;
	assign line.pkt = pkt_q;

	// sequencer never hands over the null id
	no_null_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
		op.valid && op.ready |-> op.id != NULL_ID);

endmodule

`default_nettype wire

/* verilog/hawk_axi_wr_issuer.sv */
/*
 * one line at a time on the write channels, address first then data
 * responses are in order and bready is tied high
 * idle also counts a line still offered by the packer
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_axi_wr_issuer
	import hawk_axi_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_ni,
	hawk_line_wr_if.sink      line,
	input  logic              awready,
	input  logic              wready,
	input  logic              bvalid,
	input  resp_e             bresp,
	output logic              awvalid,
	output logic              wvalid,
	output logic [ADDR_W-1:0] awaddr,
	output line_data_t        wdata,
	output line_strb_t        wstrb,
	output logic              idle,
	output logic              bus_error
);

	line_wr_t   pkt_q;    // line being issued
	logic       held;
	logic       aw_hs, w_hs, b_hs, b_ok;
	logic [7:0] pend_cnt; // aw handshakes awaiting a response

	assign held = awvalid || wvalid; // aw phase then w phase
	assign line.ready = !held;
	assign aw_hs = awvalid && awready;
	assign w_hs = wvalid && wready;
	assign b_hs = bvalid; // bready tied high
	assign b_ok = b_hs && (bresp == OKAY) && (pend_cnt != 8'd0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid <= 1'b0;
			wvalid <= 1'b0;
		end else if (line.valid && line.ready) begin
			awvalid <= 1'b1; // address next cycle
		end else if (aw_hs) begin
			awvalid <= 1'b0;
			wvalid <= 1'b1;
		end else if (w_hs) begin
			wvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (line.valid && line.ready) begin
			pkt_q <= line.pkt;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			pend_cnt <= 8'd0;
			bus_error <= 1'b0;
		end else begin
			case ({aw_hs, b_ok})
				2'b10:   pend_cnt <= pend_cnt + 8'd1;
				2'b01:   pend_cnt <= pend_cnt - 8'd1;
				default: pend_cnt <= pend_cnt; // none or both
			endcase
			if (b_hs && ((bresp != OKAY) || (pend_cnt == 8'd0))) begin
				bus_error <= 1'b1; // sticky
			end
		end
	end

	assign awaddr = pkt_q.addr;
	assign wdata = pkt_q.data;
	assign wstrb = pkt_q.strb;
	assign idle = !held && !line.valid && (pend_cnt == 8'd0);

	// stalled channels keep their payload
	aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(awaddr));
	w_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(wdata));

endmodule

`default_nettype wire

/* verilog/hawk_pgwr_mngr.sv */
/*
 * page-table write manager top
 * att and list init plus free to uncompressed page allocation
 * update caller supplies popped entry id, way and next pointer
 */
`timescale 1ns/100ps
`default_nettype none

module hawk_pgwr_mngr
	import hawk_tbl_pkg::*;
	import hawk_axi_pkg::*;
(
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              init_att,
	input  logic              init_list,
	input  logic              upd_valid,
	input  entry_id_t         upd_att_id,
	input  entry_id_t         upd_tol_id,
	input  entry_id_t         upd_next,
	input  way_t              upd_way,
	input  logic [7:0]        upd_zpd,
	input  logic              awready,
	input  logic              wready,
	input  logic              bvalid,
	input  resp_e             bresp,
	output logic              awvalid,
	output logic              wvalid,
	output logic [ADDR_W-1:0] awaddr,
	output line_data_t        wdata,
	output line_strb_t        wstrb,
	output logic              ready,
	output logic              att_init_done,
	output logic              list_init_done,
	output logic              upd_done,
	output logic              bus_error,
	output entry_id_t         free_head,
	output entry_id_t         free_tail,
	output entry_id_t         uncomp_head,
	output entry_id_t         uncomp_tail
);

	logic wr_idle; // issuer quiet

	hawk_tbl_op_if op_if ();
	hawk_line_wr_if line_if ();

	hawk_tbl_sequencer u_seq (
		.clk_i, .rst_ni, .init_att, .init_list,
		.upd_valid, .upd_att_id, .upd_tol_id, .upd_next, .upd_way, .upd_zpd,
		.idle (wr_idle),
		.op (op_if.src),
		.ready, .att_init_done, .list_init_done, .upd_done,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	hawk_line_packer u_pack (
		.clk_i, .rst_ni,
		.op (op_if.sink),
		.line (line_if.src)
	);

	hawk_axi_wr_issuer u_iss (
		.clk_i, .rst_ni,
		.line (line_if.sink),
		.awready, .wready, .bvalid, .bresp,
		.awvalid, .wvalid, .awaddr, .wdata, .wstrb,
		.idle (wr_idle),
		.bus_error
	);

endmodule

`default_nettype wire

/* tests/tb_hawk_pgwr_mngr.sv */
/*
 * att init, list init, then one update per free entry
 * memory side accepts aw and w with random stalls and responds in order
 * a final slave error response must set bus_error
 */
`timescale 1ns/100ps
`default_nettype none

module tb_hawk_pgwr_mngr
	import hawk_tbl_pkg::*;
	import hawk_axi_pkg::*;
();

	localparam logic [31:0] SEED = 32'h82a9;
	localparam int UPD_CNT = int'(LIST_ENTRY_CNT); // every free entry gets allocated
	// att init, list init, then alloc/pop/push/link minus the skipped pop and link
	localparam int EXP_WRITES = int'(ATT_ENTRY_CNT) + int'(LIST_ENTRY_CNT) + 4 * UPD_CNT - 2;
	localparam int CYCLE_LIMIT = EXP_WRITES * 40 + 2000;

	logic clk_i = 1'b0;
	logic rst_ni;
	logic init_att, init_list, upd_valid;
	entry_id_t upd_att_id, upd_tol_id, upd_next;
	way_t upd_way;
	logic [7:0] upd_zpd;
	logic awready = 1'b0; // bus model side
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	resp_e bresp = OKAY;
	logic awvalid, wvalid;
	logic [ADDR_W-1:0] awaddr;
	line_data_t wdata;
	line_strb_t wstrb;
	logic ready, att_init_done, list_init_done, upd_done, bus_error;
	entry_id_t free_head, free_tail, uncomp_head, uncomp_tail;

	logic [31:0] bus_rng = SEED;
	logic [31:0] stim_rng = SEED;
	line_wr_t exp_q[$];          // expected line writes in order
	logic [ADDR_W-1:0] aw_q[$];  // accepted addresses awaiting data
	int resp_q[$];               // response delays in order
	entry_id_t free_q[$];        // free list model with head first
	entry_id_t uc_q[$];          // uncompressed list model
	int line_errs = 0, id_errs = 0, flag_errs = 0, misc_errs = 0;
	int wr_cnt = 0;
	int done_cnt = 0;
	int cycles = 0;
	logic err_req = 1'b0;  // ask bus model for a bad response
	logic err_done = 1'b0;

	hawk_pgwr_mngr dut0 (.*);

	always #20 clk_i = ~clk_i;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// att entry in its slot of the line with 8 bytes enabled
	function automatic line_wr_t att_line(input entry_id_t id, input att_sts_e sts,
		input way_t way, input logic [7:0] zpd);
		att_entry_t ent;
		line_wr_t l;
		int slot;
		slot = (int'(id) - 1) % 8;
		ent = '0;
		ent.sts = sts;
		ent.way = way;
		ent.zpd_cnt = zpd;
		l.addr = ATT_BASE + 64'(64 * ((int'(id) - 1) / 8));
		l.data = '0;
		l.strb = '0;
		l.data[slot * 64 +: 64] = ent;
		l.strb[slot * 8 +: 8] = 8'hff;
		return l;
	endfunction

	// n bytes of a list entry from byte off with the rest of the line zero
	function automatic line_wr_t list_line(input entry_id_t id, input entry_id_t nxt,
		input entry_id_t prv, input entry_id_t aid, input way_t way, input int off, input int n);
		list_entry_t ent;
		line_wr_t l;
		int slot;
		int b;
		slot = (int'(id) - 1) % 4;
		ent = '0;
		ent.next = nxt;
		ent.prev = prv;
		ent.att_id = aid;
		ent.way = way;
		l.addr = LIST_BASE + 64'(64 * ((int'(id) - 1) / 4));
		l.data = '0;
		l.strb = '0;
		for (b = off; b < off + n; b++) begin
			l.data[(16 * slot + b) * 8 +: 8] = ent[b * 8 +: 8];
			l.strb[16 * slot + b] = 1'b1;
		end
		return l;
	endfunction

	task automatic check_line(input line_wr_t got, input line_wr_t want, input string what);
		if (got !== want) begin
			line_errs++;
			$display("[ERROR] %0t: %s addr %h strb %h, expected addr %h strb %h%s", $time,
				what, got.addr, got.strb, want.addr, want.strb,
				(got.data !== want.data) ? ", data differs" : "");
		end
	endtask

	task automatic check_id(input entry_id_t got, input entry_id_t want, input string what);
		if (got !== want) begin
			id_errs++;
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_flag(input logic got, input logic want, input string what);
		if (got !== want) begin
			flag_errs++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic expect_all_written(input string phase);
		if (exp_q.size() != 0) begin
			misc_errs++;
			$display("%0d expected line writes never appeared during %s", exp_q.size(), phase);
		end
	endtask

	task automatic check_lists();
		check_id(free_head, (free_q.size() > 0) ? free_q[0] : NULL_ID, "free_head");
		check_id(free_tail, (free_q.size() > 0) ? free_q[$] : NULL_ID, "free_tail");
		check_id(uncomp_head, (uc_q.size() > 0) ? uc_q[0] : NULL_ID, "uncomp_head");
		check_id(uncomp_tail, (uc_q.size() > 0) ? uc_q[$] : NULL_ID, "uncomp_tail");
	endtask

	// pops the model free head and pushes it on the uncompressed tail
	task automatic run_update();
		entry_id_t tol, nxt, old_tail, aid;
		way_t way;
		logic [7:0] zpd;
		tol = free_q[0];
		nxt = (free_q.size() > 1) ? free_q[1] : NULL_ID;
		old_tail = (uc_q.size() > 0) ? uc_q[$] : NULL_ID;
		stim_rng = xorshift(stim_rng);
		aid = entry_id_t'(stim_rng[3:0]) + 24'd1; // any att entry
		zpd = stim_rng[15:8];
		way = PPA_BASE_PAGE + way_t'(tol) - 48'd1; // page of the popped entry
		exp_q.push_back(att_line(aid, UNCOMP, way, zpd));
		if (nxt != NULL_ID) begin
			exp_q.push_back(list_line(nxt, NULL_ID, NULL_ID, NULL_ID, '0, 3, 3));
		end
		exp_q.push_back(list_line(tol, NULL_ID, old_tail, aid, '0, 0, 9));
		if (old_tail != NULL_ID) begin
			exp_q.push_back(list_line(old_tail, tol, NULL_ID, NULL_ID, '0, 0, 3));
		end
		void'(free_q.pop_front());
		uc_q.push_back(tol);
		do @(posedge clk_i); while (!ready);
		upd_valid <= 1'b1;
		upd_att_id <= aid;
		upd_tol_id <= tol;
		upd_next <= nxt;
		upd_way <= way;
		upd_zpd <= zpd;
		@(posedge clk_i); // taken here as ready is still high
		upd_valid <= 1'b0;
		while (!upd_done) @(posedge clk_i);
		expect_all_written("update");
		check_lists();
		@(posedge clk_i);
		check_flag(upd_done, 1'b0, "upd_done one cycle later");
	endtask

	// memory side with random stalls and in order responses after random delay
	always @(posedge clk_i) begin : bus_model
		line_wr_t got;
		bus_rng = xorshift(bus_rng);
		awready <= bus_rng[0] | bus_rng[1]; // ready 3 of 4 cycles
		wready <= bus_rng[2] | bus_rng[3];
		if (awvalid && awready) begin
			aw_q.push_back(awaddr);
		end
		if (wvalid && wready) begin
			wr_cnt <= wr_cnt + 1;
			resp_q.push_back(int'(bus_rng[5:4]));
			if (aw_q.size() == 0 || exp_q.size() == 0) begin
				misc_errs++;
				$display("line write at %0t with no address or no expected write", $time);
			end else begin
				got.addr = aw_q.pop_front();
				got.data = wdata;
				got.strb = wstrb;
				check_line(got, exp_q.pop_front(), "line write");
			end
		end
		if (bvalid) begin // bready is always high
			bvalid <= 1'b0;
			bresp <= OKAY;
			if (bresp != OKAY) begin
				err_done <= 1'b1;
			end
		end else if (resp_q.size() > 0) begin
			if (resp_q[0] == 0) begin
				bvalid <= 1'b1;
				void'(resp_q.pop_front());
			end else begin
				resp_q[0] = resp_q[0] - 1;
			end
		end else if (err_req && !err_done) begin
			bvalid <= 1'b1; // response nobody asked for
			bresp <= SLVERR;
		end
	end

	always @(posedge clk_i) begin
		if (upd_done) begin
			done_cnt <= done_cnt + 1;
		end
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles before the tests finished", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		int id;
		rst_ni = 1'b0;
		init_att = 1'b0;
		init_list = 1'b0;
		upd_valid = 1'b0;
		upd_att_id = NULL_ID;
		upd_tol_id = NULL_ID;
		upd_next = NULL_ID;
		upd_way = '0;
		upd_zpd = 8'd0;
		repeat (5) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(posedge clk_i);
		check_flag(awvalid, 1'b0, "awvalid after reset");
		check_flag(wvalid, 1'b0, "wvalid after reset");
		check_flag(upd_done, 1'b0, "upd_done after reset");
		check_flag(att_init_done, 1'b0, "att_init_done after reset");
		check_flag(list_init_done, 1'b0, "list_init_done after reset");
		check_flag(bus_error, 1'b0, "bus_error after reset");
		check_flag(ready, 1'b1, "ready after reset");

		for (id = 1; id <= int'(ATT_ENTRY_CNT); id++) begin
			exp_q.push_back(att_line(entry_id_t'(id), DALLOC, '0, 8'd0));
		end
		init_att <= 1'b1;
		while (!att_init_done) @(posedge clk_i);
		expect_all_written("att init");
		check_flag(list_init_done, 1'b0, "list_init_done after att init");

		for (id = 1; id <= int'(LIST_ENTRY_CNT); id++) begin
			exp_q.push_back(list_line(entry_id_t'(id),
				(id == int'(LIST_ENTRY_CNT)) ? NULL_ID : entry_id_t'(id + 1),
				entry_id_t'(id - 1), NULL_ID,
				PPA_BASE_PAGE + way_t'(id - 1), 0, 16));
			free_q.push_back(entry_id_t'(id));
		end
		init_list <= 1'b1;
		while (!list_init_done) @(posedge clk_i);
		expect_all_written("list init");
		check_lists(); // free 1..N and uncompressed empty

		repeat (UPD_CNT) run_update();
		if (done_cnt != UPD_CNT || wr_cnt != EXP_WRITES) begin
			misc_errs++;
			$display("[ERROR] %0t: saw %0d upd_done pulses and %0d writes, expected %0d and %0d",
				$time, done_cnt, wr_cnt, UPD_CNT, EXP_WRITES);
		end
		check_flag(bus_error, 1'b0, "bus_error before injected response");

		err_req <= 1'b1;
		while (!err_done) @(posedge clk_i);
		check_flag(bus_error, 1'b1, "bus_error after injected response");

		$display("errors: line %0d, id %0d, flag %0d, other %0d",
			line_errs, id_errs, flag_errs, misc_errs);
		if (line_errs + id_errs + flag_errs + misc_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hawk_pgwr.f */
verilog/hawk_tbl_pkg.sv
verilog/hawk_axi_pkg.sv
verilog/hawk_tbl_op_if.sv
verilog/hawk_line_wr_if.sv
verilog/hawk_tbl_sequencer.sv
verilog/hawk_line_packer.sv
verilog/hawk_axi_wr_issuer.sv
verilog/hawk_pgwr_mngr.sv
tests/tb_hawk_pgwr_mngr.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_hawk_pgwr_mngr \
	-f hawk_pgwr.f \
	--Mdir build -o sim \
	&& ./build/sim 2>&1 | tee sim.log \
	&& grep -qx "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
